/* include/afu_edge_consts.svh */
// ====================
// Constants shared by the accelerator edge for bus widths, heap sizing
// and flow control thresholds
// ====================

`ifndef AFU_EDGE_CONSTS_SVH
`define AFU_EDGE_CONSTS_SVH

// Cache-line address counted in 64-byte lines
`define CL_ADDR_WIDTH 42

// One full cache line of write data
`define CL_DATA_WIDTH 512

// Request tag returned unchanged with the response
`define MDATA_WIDTH 16

// Number of line slots in the external write data store
`define WRITE_HEAP_ENTRIES 32

// Requests the pipeline must still absorb after almost-full is raised
`define ALMOST_FULL_THRESHOLD 8

// Largest multi-line write packet, in beats
`define MAX_MULTI_LINE_BEATS 4

// Slots held back so a packet in flight plus the threshold always fits
`define HEAP_MIN_FREE (`ALMOST_FULL_THRESHOLD + `MAX_MULTI_LINE_BEATS + 1)

`endif

/* hw/edge_pkg.sv */
// ====================
// Write heap types for slot indices, beat numbers and the heap store port
// ====================

`include "afu_edge_consts.svh"

package edge_pkg;

    // ====================
    // Heap addressing
    // ====================

    // One slot holds every beat of one write packet
    typedef logic [$clog2(`WRITE_HEAP_ENTRIES)-1:0] heap_idx_t;

    // Position of a beat inside its packet where the sop beat is 0
    typedef logic [$clog2(`MAX_MULTI_LINE_BEATS)-1:0] beat_num_t;

    // ====================
    // Heap store port
    // ====================

    // The store is addressed by slot and beat together.
    // A single-line write always lands in beat 0
    typedef struct packed {
        logic                      en;
        heap_idx_t                 heap_idx;
        beat_num_t                 beat_num;
        logic [`CL_DATA_WIDTH-1:0] data;
    } heap_wr_t;

endpackage

/* hw/ccip_pkg.sv */
// ====================
// Request channel types seen at the accelerator side and at the pipeline
// ====================

`include "afu_edge_consts.svh"

package ccip_pkg;

    // Collapsed writes name their heap slot instead of carrying data
    import edge_pkg::*;

    // ====================
    // Request header
    // ====================

    // Line-count code of a request.
    // Codes 0, 1 and 3 stand for 1, 2 and 4 lines, and the code
    // doubles as the number of the last beat of a write packet
    typedef logic [1:0] cl_len_t;

    // Common header of reads and writes.
    // On non-sop write beats address and cl_len are don't-care
    typedef struct packed {
        logic [`CL_ADDR_WIDTH-1:0] address;
        cl_len_t                   cl_len;
        logic [`MDATA_WIDTH-1:0]   mdata;
        logic                      sop;
    } req_hdr_t;

    // ====================
    // Channel requests
    // ====================

    // Read request, identical on both sides of the edge
    typedef struct packed {
        logic     valid;
        req_hdr_t hdr;
    } c0_req_t;

    // One write beat from the accelerator, with its line of data
    typedef struct packed {
        logic                      valid;
        req_hdr_t                  hdr;
        logic [`CL_DATA_WIDTH-1:0] data;
    } c1_req_t;

    // Collapsed write toward the pipeline.
    // The data already sits in the heap at heap_idx
    typedef struct packed {
        logic      valid;
        req_hdr_t  hdr;
        heap_idx_t heap_idx;
    } c1_ctrl_t;

endpackage

/* hw/write_heap_ctrl.sv */
// ====================
// Free-list allocator of write heap slots, keeping a reserve for writes
// that are already on their way
// ====================

`timescale 1ns/1ps

`include "afu_edge_consts.svh"

module write_heap_ctrl
    import edge_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      alloc,
    output heap_idx_t alloc_idx,
    output logic      heap_avail,
    input  logic      free,
    input  heap_idx_t free_idx
);

    localparam int ENTRIES = `WRITE_HEAP_ENTRIES;

    // One extra bit so that a completely free heap can be counted
    typedef logic [$clog2(ENTRIES):0] count_t;

    // ====================
    // Free list storage
    // ====================

    // Circular FIFO of free slots.
    // With a power-of-two size the pointers wrap on their own
    heap_idx_t free_list [ENTRIES];
    heap_idx_t head;
    heap_idx_t tail;
    count_t    free_count;

    // At reset every slot is free and handed out in ascending order.
    // A returned slot goes to the tail, behind all slots still waiting
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < ENTRIES; i++)
            begin
                free_list[i] <= heap_idx_t'(i);
            end
        end
        else if (free)
        begin
            free_list[tail] <= free_idx;
        end
    end

    // The head of the list is the slot for the next packet
    assign alloc_idx = free_list[head];

    // ====================
    // Pointers and count
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head       <= '0;
            tail       <= '0;
            free_count <= count_t'(ENTRIES);
        end
        else
        begin
            if (alloc)
            begin
                head <= head + heap_idx_t'(1);
            end

            if (free)
            begin
                tail <= tail + heap_idx_t'(1);
            end

            // A free and an alloc in the same cycle leave the count alone
            case ({alloc, free})
                2'b10:   free_count <= free_count - count_t'(1);
                2'b01:   free_count <= free_count + count_t'(1);
                default: free_count <= free_count;
            endcase
        end
    end

    // Registered reserve check that lags the count by one cycle.
    // The reserve covers this lag as well as the accelerator's reaction time
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            heap_avail <= 1'b1;
        end
        else
        begin
            heap_avail <= (free_count > count_t'(`HEAP_MIN_FREE));
        end
    end

endmodule

/* hw/write_packet_tracker.sv */
// ====================
// Beat tracker for multi-line writes that rebuilds the sop header on
// later beats and flags the last beat
// ====================

`timescale 1ns/1ps

`include "afu_edge_consts.svh"

module write_packet_tracker
    import ccip_pkg::*;
    import edge_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  c1_req_t   beat,
    output req_hdr_t  canon_hdr,
    output beat_num_t beat_num,
    output logic      eop,
    output logic      packet_active
);

    // Address and length from the latest sop beat.
    // Later beats of the packet may carry anything in these fields
    logic [`CL_ADDR_WIDTH-1:0] sop_address;
    cl_len_t                   sop_cl_len;

    // Beat count of the packet in progress
    beat_num_t beat_cnt;

    // ====================
    // Header recovery
    // ====================

    always_ff @(posedge clk)
    begin
        if (beat.valid && beat.hdr.sop)
        begin
            sop_address <= beat.hdr.address;
            sop_cl_len  <= beat.hdr.cl_len;
        end
    end

    // The sop beat supplies its own header.
    // Every other beat borrows the saved address and length
    always_comb
    begin
        canon_hdr = beat.hdr;
        if (!beat.hdr.sop)
        begin
            canon_hdr.address = sop_address;
            canon_hdr.cl_len  = sop_cl_len;
        end
    end

    // ====================
    // Beat counting
    // ====================

    assign beat_num = beat_cnt;

    // The length code equals the number of the final beat
    assign eop = beat.valid && (beat_cnt == beat_num_t'(canon_hdr.cl_len));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beat_cnt      <= '0;
            packet_active <= 1'b0;
        end
        else if (beat.valid)
        begin
            beat_cnt      <= eop ? '0 : beat_cnt + beat_num_t'(1);
            // Stays low across single-line writes
            packet_active <= !eop;
        end
    end

endmodule

/* hw/write_flow_ctrl.sv */
// ====================
// Registered almost-full toward the accelerator, held off while a
// write packet is still arriving
// ====================

`timescale 1ns/1ps

module write_flow_ctrl
(
    input  logic clk,
    input  logic reset,
    input  logic fiu_c0_alm_full,
    input  logic fiu_c1_alm_full,
    input  logic heap_avail,
    input  logic packet_active,
    output logic afu_c0_alm_full,
    output logic afu_c1_alm_full
);

    // Writes must stop when the pipeline fills or the heap reserve is reached
    logic write_full;

    // Set once write-full has been seen between packets
    logic sticky_full;

    assign write_full = fiu_c1_alm_full || !heap_avail;

    // ====================
    // Almost-full registers
    // ====================

    // A packet that has started must be allowed to finish, since its
    // slot is already taken and the control request is not yet sent.
    // The heap reserve absorbs the remaining beats
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            afu_c0_alm_full <= 1'b1;
            afu_c1_alm_full <= 1'b1;
            sticky_full     <= 1'b0;
        end
        else
        begin
            afu_c0_alm_full <= fiu_c0_alm_full;
            afu_c1_alm_full <= write_full && (!packet_active || sticky_full);

            if (!write_full)
            begin
                sticky_full <= 1'b0;
            end
            else if (!packet_active)
            begin
                sticky_full <= 1'b1;
            end
        end
    end

endmodule

/* hw/afu_edge.sv */
// ====================
// Accelerator edge of the request pipeline that stores write data in the
// heap and sends one control request per write packet
// ====================

`timescale 1ns/1ps

module afu_edge
    import ccip_pkg::*;
    import edge_pkg::*;
#(
    parameter int ENFORCE_WR_ORDER = 1
)
(
    input  logic      clk,
    input  logic      reset,
    input  c0_req_t   afu_c0,
    input  c1_req_t   afu_c1,
    input  logic      fiu_c0_alm_full,
    input  logic      fiu_c1_alm_full,
    input  logic      heap_free,
    input  heap_idx_t heap_free_idx,
    output c0_req_t   fiu_c0,
    output c1_ctrl_t  fiu_c1,
    output heap_wr_t  heap_wr,
    output logic      afu_c0_alm_full,
    output logic      afu_c1_alm_full,
    output logic      afu_reset
);

    heap_idx_t alloc_idx;
    logic      heap_avail;
    logic      wr_eop;
    logic      packet_active;
    req_hdr_t  canon_hdr;
    beat_num_t beat_num;

    // The accelerator leaves reset one cycle after the pipeline
    always_ff @(posedge clk)
    begin
        afu_reset <= reset;
    end

    // ====================
    // Read path
    // ====================

    // Writes leave through a register, so reads take the same delay
    // when their order against writes must hold
    generate
        if (ENFORCE_WR_ORDER != 0)
        begin : g_rd_reg
            always_ff @(posedge clk)
            begin
                fiu_c0.hdr <= afu_c0.hdr;
                if (reset)
                begin
                    fiu_c0.valid <= 1'b0;
                end
                else
                begin
                    fiu_c0.valid <= afu_c0.valid;
                end
            end
        end
        else
        begin : g_rd_direct
            assign fiu_c0 = afu_c0;
        end
    endgenerate

    // ====================
    // Write path
    // ====================

    write_packet_tracker u_tracker (
        .clk           (clk),
        .reset         (reset),
        .beat          (afu_c1),
        .canon_hdr     (canon_hdr),
        .beat_num      (beat_num),
        .eop           (wr_eop),
        .packet_active (packet_active)
    );

    // The slot is taken only at the end of the packet, so every
    // beat of the packet sees the same head of the free list
    write_heap_ctrl u_heap_ctrl (
        .clk        (clk),
        .reset      (reset),
        .alloc      (wr_eop),
        .alloc_idx  (alloc_idx),
        .heap_avail (heap_avail),
        .free       (heap_free),
        .free_idx   (heap_free_idx)
    );

    // Each valid beat goes straight to the data store
    always_comb
    begin
        heap_wr.en       = afu_c1.valid;
        heap_wr.heap_idx = alloc_idx;
        heap_wr.beat_num = beat_num;
        heap_wr.data     = afu_c1.data;
    end

    // One control request per packet, sent once all its data is stored.
    // It carries the recovered sop header
    always_ff @(posedge clk)
    begin
        fiu_c1.hdr      <= canon_hdr;
        fiu_c1.hdr.sop  <= 1'b1;
        fiu_c1.heap_idx <= alloc_idx;
        if (reset)
        begin
            fiu_c1.valid <= 1'b0;
        end
        else
        begin
            fiu_c1.valid <= wr_eop;
        end
    end

    write_flow_ctrl u_flow_ctrl (
        .clk             (clk),
        .reset           (reset),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .fiu_c1_alm_full (fiu_c1_alm_full),
        .heap_avail      (heap_avail),
        .packet_active   (packet_active),
        .afu_c0_alm_full (afu_c0_alm_full),
        .afu_c1_alm_full (afu_c1_alm_full)
    );

endmodule

/* testbench/tb_afu_edge_tasks.svh */
// ====================
// Stimulus, compare and wait tasks plus the directed tests of the edge
// ====================

// ====================
// Compare tasks
// ====================

task automatic check_c0(input string what, input c0_req_t got, input c0_req_t exp);
    checks_run++;
    if (got !== exp)
    begin
        value_errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_c1(input string what, input c1_ctrl_t got, input c1_ctrl_t exp);
    checks_run++;
    if (got !== exp)
    begin
        value_errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_heap_wr(input string what, input heap_wr_t got, input heap_wr_t exp);
    checks_run++;
    if (got !== exp)
    begin
        value_errors++;
        // Slot and beat number come first, a data mismatch gets a line of its own
        $display("CHECK FAILED at %0t: %s en/slot/beat got %b/%0d/%0d expected %b/%0d/%0d",
                 $time, what, got.en, got.heap_idx, got.beat_num,
                 exp.en, exp.heap_idx, exp.beat_num);
        if (got.data !== exp.data)
        begin
            $display("CHECK FAILED at %0t: %s data mismatch", $time, what);
        end
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    checks_run++;
    if (got !== exp)
    begin
        value_errors++;
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

// Called at a falling edge and polls afu_c1_alm_full once per cycle
task automatic wait_c1_alm_full(input logic level, input int max_cycles);
    int waited;
    waited = 0;
    while (afu_c1_alm_full !== level && waited < max_cycles)
    begin
        @(negedge clk);
        waited++;
    end
    if (afu_c1_alm_full !== level)
    begin
        timeout_errors++;
        $display("Timeout: afu_c1_alm_full did not reach %b within %0d cycles",
                 level, max_cycles);
    end
endtask

// ====================
// Stimulus helpers
// ====================

function automatic logic [`CL_DATA_WIDTH-1:0] random_line();
    logic [`CL_DATA_WIDTH-1:0] line;
    for (int w = 0; w < `CL_DATA_WIDTH / 32; w++)
    begin
        line[w*32 +: 32] = $urandom;
    end
    return line;
endfunction

function automatic req_hdr_t random_hdr(input logic sop);
    req_hdr_t    hdr;
    logic [63:0] wide;
    wide        = {$urandom, $urandom};
    hdr.address = wide[`CL_ADDR_WIDTH-1:0];
    wide        = {$urandom, $urandom};
    hdr.mdata   = wide[`MDATA_WIDTH-1:0];
    hdr.cl_len  = wide[`MDATA_WIDTH +: 2];
    hdr.sop     = sop;
    return hdr;
endfunction

// Sends one write packet and checks each heap store against the expected slot.
// Non-sop beats carry random address and length, which the DUT must ignore.
// fiu_c1_alm_full goes high together with beat raise_at
// A negative raise_at leaves it alone
task automatic send_write(input cl_len_t len, input heap_idx_t slot,
                          input int raise_at, input logic free_after);
    req_hdr_t first_hdr;
    c1_req_t  beat;
    heap_wr_t exp_wr;
    c1_ctrl_t exp_ctrl;
    int       beats;

    beats            = int'(len) + 1;
    first_hdr        = random_hdr(1'b1);
    first_hdr.cl_len = len;
    for (int b = 0; b < beats; b++)
    begin
        beat.valid = 1'b1;
        beat.hdr   = (b == 0) ? first_hdr : random_hdr(1'b0);
        beat.hdr.mdata = first_hdr.mdata;
        beat.data  = random_line();
        @(posedge clk);
        afu_c1 <= beat;
        if (b == raise_at)
        begin
            fiu_c1_alm_full <= 1'b1;
        end
        @(negedge clk);
        exp_wr.en       = 1'b1;
        exp_wr.heap_idx = slot;
        exp_wr.beat_num = beat_num_t'(b);
        exp_wr.data     = beat.data;
        check_heap_wr("heap_wr beat", heap_wr, exp_wr);
        check_bit("fiu_c1 quiet before packet end", fiu_c1.valid, 1'b0);
        if (raise_at >= 0)
        begin
            check_bit("afu_c1_alm_full held off inside packet", afu_c1_alm_full, 1'b0);
        end
    end

    // Optional return of the slot right after the packet leaves
    @(posedge clk);
    afu_c1 <= '0;
    if (free_after)
    begin
        heap_free     <= 1'b1;
        heap_free_idx <= slot;
    end
    @(negedge clk);
    exp_ctrl.valid    = 1'b1;
    exp_ctrl.hdr      = first_hdr;
    exp_ctrl.heap_idx = slot;
    check_c1("fiu_c1 after last beat", fiu_c1, exp_ctrl);
    @(posedge clk);
    heap_free <= 1'b0;
    @(negedge clk);
    check_bit("one fiu_c1 per packet", fiu_c1.valid, 1'b0);
endtask

// ====================
// Directed tests
// ====================

task automatic test_reset();
    // Registered outputs take their reset value at the first edge
    @(posedge clk);
    for (int c = 1; c < 16; c++)
    begin
        @(negedge clk);
        check_bit("afu_c0_alm_full in reset", afu_c0_alm_full, 1'b1);
        check_bit("afu_c1_alm_full in reset", afu_c1_alm_full, 1'b1);
        check_bit("afu_reset in reset", afu_reset, 1'b1);
        @(posedge clk);
    end
    reset <= 1'b0;
    @(negedge clk);
    check_bit("afu_reset one cycle after reset", afu_reset, 1'b1);
    @(negedge clk);
    check_bit("afu_reset released", afu_reset, 1'b0);
    check_bit("afu_c0_alm_full after reset", afu_c0_alm_full, 1'b0);
    check_bit("afu_c1_alm_full after reset", afu_c1_alm_full, 1'b0);
endtask

task automatic test_read_path();
    c0_req_t rd;
    rd.valid = 1'b1;
    rd.hdr   = random_hdr(1'b1);
    @(posedge clk);
    afu_c0 <= rd;
    @(negedge clk);
    check_bit("fiu_c0 not in same cycle", fiu_c0.valid, 1'b0);
    @(posedge clk);
    afu_c0 <= '0;
    @(negedge clk);
    check_c0("fiu_c0 one cycle later", fiu_c0, rd);
    @(negedge clk);
    check_bit("fiu_c0 single pulse", fiu_c0.valid, 1'b0);
endtask

// Fresh slots come out in ascending order
task automatic test_single_write();
    send_write(2'd0, heap_idx_t'(0), -1, 1'b0);
    send_write(2'd0, heap_idx_t'(1), -1, 1'b0);
endtask

task automatic test_multi_write();
    send_write(2'd3, heap_idx_t'(2), -1, 1'b0);
endtask

task automatic test_flow_control();
    send_write(2'd3, heap_idx_t'(3), 2, 1'b0);
    wait_c1_alm_full(1'b1, 1);
    @(posedge clk);
    fiu_c0_alm_full <= 1'b1;
    @(negedge clk);
    check_bit("afu_c0_alm_full not yet", afu_c0_alm_full, 1'b0);
    @(negedge clk);
    check_bit("afu_c0_alm_full one cycle later", afu_c0_alm_full, 1'b1);
    @(posedge clk);
    fiu_c0_alm_full <= 1'b0;
    fiu_c1_alm_full <= 1'b0;
    @(negedge clk);
    wait_c1_alm_full(1'b0, 3);
endtask

// Slots 4 to 18 bring the free count down to the reserve of 13
task automatic test_heap_reuse();
    for (int s = 4; s < 19; s++)
    begin
        check_bit("afu_c1_alm_full before reserve", afu_c1_alm_full, 1'b0);
        send_write(2'd0, heap_idx_t'(s), -1, 1'b0);
    end
    wait_c1_alm_full(1'b1, 3);

    @(posedge clk);
    heap_free     <= 1'b1;
    heap_free_idx <= heap_idx_t'(3);
    @(posedge clk);
    heap_free <= 1'b0;
    @(negedge clk);
    wait_c1_alm_full(1'b0, 4);

    // Slot 3 waits behind the untouched initial slots 19 to 31
    for (int s = 19; s < 32; s++)
    begin
        send_write(2'd0, heap_idx_t'(s), -1, 1'b1);
    end
    send_write(2'd0, heap_idx_t'(3), -1, 1'b1);
endtask

/* testbench/tb_afu_edge.sv */
// ====================
// Testbench of the accelerator edge with a fake heap free path
// ====================

`timescale 1ns/1ps

`include "afu_edge_consts.svh"

module tb_afu_edge
    import ccip_pkg::*;
    import edge_pkg::*;
();

    logic      clk;
    logic      reset;
    c0_req_t   afu_c0;
    c1_req_t   afu_c1;
    logic      fiu_c0_alm_full;
    logic      fiu_c1_alm_full;
    logic      heap_free;
    heap_idx_t heap_free_idx;
    c0_req_t   fiu_c0;
    c1_ctrl_t  fiu_c1;
    heap_wr_t  heap_wr;
    logic      afu_c0_alm_full;
    logic      afu_c1_alm_full;
    logic      afu_reset;

    // Result bookkeeping for the closing summary
    int checks_run;
    int value_errors;
    int timeout_errors;

    // 8 ns clock period
    always #4 clk = ~clk;

    afu_edge #(
        .ENFORCE_WR_ORDER (1)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .afu_c0          (afu_c0),
        .afu_c1          (afu_c1),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .fiu_c1_alm_full (fiu_c1_alm_full),
        .heap_free       (heap_free),
        .heap_free_idx   (heap_free_idx),
        .fiu_c0          (fiu_c0),
        .fiu_c1          (fiu_c1),
        .heap_wr         (heap_wr),
        .afu_c0_alm_full (afu_c0_alm_full),
        .afu_c1_alm_full (afu_c1_alm_full),
        .afu_reset       (afu_reset)
    );

    `include "tb_afu_edge_tasks.svh"

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        int unused_seed;

        clk             = 1'b0;
        reset           = 1'b1;
        afu_c0          = '0;
        afu_c1          = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_c1_alm_full = 1'b0;
        heap_free       = 1'b0;
        heap_free_idx   = '0;
        checks_run      = 0;
        value_errors    = 0;
        timeout_errors  = 0;

        // Data and addresses all come from this one seeded stream
        unused_seed = $urandom(97);

        // Reset is released inside the first test
        test_reset();
        test_read_path();
        test_single_write();
        test_multi_write();
        test_flow_control();
        test_heap_reuse();

        repeat (4) @(posedge clk);
        $display("Summary: %0d checks, %0d value errors, %0d timeouts",
                 checks_run, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
+incdir+testbench
hw/edge_pkg.sv
hw/ccip_pkg.sv
hw/write_heap_ctrl.sv
hw/write_packet_tracker.sv
hw/write_flow_ctrl.sv
hw/afu_edge.sv
testbench/tb_afu_edge.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_afu_edge
FILELIST = all.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
